/* src.f */
+incdir+hw
hw/sram_fifo_pkg.sv
hw/queue_pointers.sv
hw/drain_arbiter.sv
hw/burst_reader.sv
hw/sram_model.sv
hw/output_fifo.sv
hw/sram_fifo_drain.sv
sim/tb_sram_fifo_drain.sv

/* Bender.yml */
package:
  name: sram_fifo_drain

sources:
  - include_dirs:
      - hw
    files:
      - hw/sram_fifo_pkg.sv
      - hw/queue_pointers.sv
      - hw/drain_arbiter.sv
      - hw/burst_reader.sv
      - hw/sram_model.sv
      - hw/output_fifo.sv
      - hw/sram_fifo_drain.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_sram_fifo_drain.sv

/* sim/tb_sram_fifo_drain.sv */
// SRAM packet buffer drain testbench
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_macros.svh"

module tb_sram_fifo_drain;

    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_ROWS   = 9;
    localparam int W          = `SF_WORD_W;

    logic                                   memclk;
    logic                                   reset;
    logic                                   wr_valid;
    sram_fifo_pkg::qid_t                    wr_queue;
    sram_fifo_pkg::word_t                   wr_data;
    sram_fifo_pkg::qmask_t                  out_rd_en;
    sram_fifo_pkg::qmask_t                  wr_full;
    logic [`SF_NUM_QUEUES*`SF_WORD_W-1:0]   out_data;
    sram_fifo_pkg::qmask_t                  out_empty;

    // ***********************************************************************
    // Stimulus table, one row per write phase.
    // ***********************************************************************
    // Hold pauses the consumer of that queue.
    int          row_queue  [NUM_ROWS] = '{0, 1, 2, 3, 0, 1, 2, 3, 1};
    int          row_bursts [NUM_ROWS] = '{2, 1, 3, 2, 2, 2, 0, 9, 3};
    logic [31:0] row_base   [NUM_ROWS] = '{32'h1000_0000, 32'h2000_0000, 32'h3000_0000,
                                           32'h4000_0000, 32'h1100_0000, 32'h2100_0000,
                                           32'h3100_0000, 32'h4100_0000, 32'h2200_0000};
    bit          row_hold   [NUM_ROWS] = '{0, 0, 1, 0, 0, 0, 0, 1, 0};
    bit          row_drain  [NUM_ROWS] = '{0, 0, 0, 0, 0, 1, 1, 1, 1};
    bit          row_full   [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 1, 0};

    // Expected words, oldest first.
    sram_fifo_pkg::word_t   sb [`SF_NUM_QUEUES][$];
    sram_fifo_pkg::qmask_t  paused;
    sram_fifo_pkg::qmask_t  full_seen;
    int                     errors;
    int                     written;
    int                     delivered;
    int                     seed;
    logic [31:0]            rnd;

    sram_fifo_drain DUT
    (
        .memclk    (memclk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_queue  (wr_queue),
        .wr_data   (wr_data),
        .out_rd_en (out_rd_en),
        .wr_full   (wr_full),
        .out_data  (out_data),
        .out_empty (out_empty)
    );

    always #5 memclk = ~memclk;

    task automatic check_word(input string name, input sram_fifo_pkg::word_t expected,
                              input sram_fifo_pkg::word_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_mask(input string name, input sram_fifo_pkg::qmask_t expected,
                              input sram_fifo_pkg::qmask_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // Closing line and verdict.
    task automatic finish_run();
        $display("Errors: %0d, words written: %0d, words delivered: %0d",
                 errors, written, delivered);
        if (errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // Words still expected on the masked queues.
    function automatic int pending(input sram_fifo_pkg::qmask_t m);
        int n;
        n = 0;
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            if (m[q])
            begin
                n += sb[q].size();
            end
        end
        return n;
    endfunction

    // Hold one word until the region has room.
    task automatic send_word(input sram_fifo_pkg::qid_t q, input sram_fifo_pkg::word_t w);
        int waited;
        waited = 0;
        @(posedge memclk);
        wr_valid <= 1'b1;
        wr_queue <= q;
        wr_data  <= w;
        @(negedge memclk);
        while (wr_full[q] && (waited < WAIT_LIMIT))
        begin
            // Release the consumer until the region has room.
            full_seen[q] = 1'b1;
            paused[q]   <= 1'b0;
            @(negedge memclk);
            waited++;
        end
        if (wr_full[q])
        begin
            report_timeout("Timeout: wr_full never fell while the writer was waiting");
        end
        else
        begin
            sb[q].push_back(w);
            written++;
        end
    endtask

    task automatic write_row(input int r);
        logic [31:0]          payload;
        sram_fifo_pkg::word_t w;
        for (int i = 0; i < row_bursts[r] * `SF_BURST_LEN; i++)
        begin
            payload = row_base[r] + i;
            // EOP on the last word of each burst.
            w = {(i % `SF_BURST_LEN) == (`SF_BURST_LEN - 1), payload};
            send_word(sram_fifo_pkg::qid_t'(row_queue[r]), w);
        end
        @(posedge memclk);
        wr_valid <= 1'b0;
    endtask

    // Wait until every unpaused queue has delivered what was written.
    task automatic wait_drained(input bit all_idle);
        int waited;
        waited = 0;
        while (((pending(~paused) != 0) || (all_idle && (out_empty != '1)))
               && (waited < WAIT_LIMIT))
        begin
            @(posedge memclk);
            waited++;
        end
        if ((pending(~paused) != 0) || (all_idle && (out_empty != '1)))
        begin
            report_timeout("Timeout: output queues did not drain");
        end
    endtask

    // ***********************************************************************
    // Consumer with a random read pattern.
    // ***********************************************************************
    always @(posedge memclk)
    begin
        if (reset)
        begin
            out_rd_en <= '0;
        end
        else
        begin
            rnd = $random(seed);
            out_rd_en <= rnd[`SF_NUM_QUEUES-1:0] & ~paused & ~out_empty;
        end
    end

    // Reads take effect at the next rising edge.
    always @(negedge memclk)
    begin
        if (!reset)
        begin
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                if (out_rd_en[q] && !out_empty[q])
                begin
                    if (sb[q].size() == 0)
                    begin
                        errors++;
                        $display("Queue %0d delivered a word that was never written", q);
                    end
                    else
                    begin
                        check_word($sformatf("queue %0d word", q), sb[q].pop_front(),
                                   out_data[q*W +: W]);
                    end
                    delivered++;
                end
            end
        end
    end

    initial
    begin
        sram_fifo_pkg::qmask_t bitm;
        memclk    = 1'b0;
        reset     = 1'b1;
        wr_valid  = 1'b0;
        wr_queue  = '0;
        wr_data   = '0;
        out_rd_en = '0;
        paused    = '0;
        full_seen = '0;
        errors    = 0;
        written   = 0;
        delivered = 0;
        seed      = 32'h92f5;
        repeat (4) @(posedge memclk);
        reset <= 1'b0;
        @(negedge memclk);
        check_mask("reset out_empty", '1, out_empty);
        check_mask("reset wr_full", '0, wr_full);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            bitm = sram_fifo_pkg::qmask_t'(1) << row_queue[r];
            @(posedge memclk);
            paused[row_queue[r]] <= row_hold[r];
            write_row(r);
            check_mask($sformatf("row %0d wr_full raised", r),
                       row_full[r] ? bitm : '0, full_seen & bitm);
            if (row_drain[r])
            begin
                wait_drained(1'b0);
            end
        end

        // Release everything and empty the buffer.
        @(posedge memclk);
        paused <= '0;
        @(posedge memclk);
        wait_drained(1'b1);
        repeat (2) @(negedge memclk);
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            check_count($sformatf("queue %0d words left", q), 0, sb[q].size());
        end
        check_mask("final out_empty", '1, out_empty);
        check_mask("final wr_full", '0, wr_full);
        check_count("words delivered", written, delivered);
        finish_run();
    end

endmodule

`default_nettype wire

/* hw/sram_fifo_drain.sv */
// SRAM packet buffer drain top
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_macros.svh"

module sram_fifo_drain
(
    input  wire logic                               memclk,
    input  wire logic                               reset,
    input  wire logic                               wr_valid,
    input  sram_fifo_pkg::qid_t                     wr_queue,
    input  sram_fifo_pkg::word_t                    wr_data,
    input  sram_fifo_pkg::qmask_t                   out_rd_en,
    output sram_fifo_pkg::qmask_t                   wr_full,
    output logic [`SF_NUM_QUEUES*`SF_WORD_W-1:0]    out_data,
    output sram_fifo_pkg::qmask_t                   out_empty
);

    // SRAM ports.
    logic                   wr_en;
    sram_fifo_pkg::addr_t   wr_addr;
    logic                   rd_en;
    sram_fifo_pkg::addr_t   sram_addr;
    sram_fifo_pkg::word_t   rd_data;

    // Queue status and selection.
    sram_fifo_pkg::addr_t   rd_addr;
    sram_fifo_pkg::qmask_t  mem_queue_empty;
    sram_fifo_pkg::qmask_t  fifo_full;
    sram_fifo_pkg::qid_t    queue_id;
    sram_fifo_pkg::qmask_t  burst_inc;
    logic                   read_burst;

    // Returned words.
    logic                   din_valid;
    sram_fifo_pkg::word_t   din;
    sram_fifo_pkg::qid_t    din_queue_id;
    logic [`SF_NUM_QUEUES*`SF_WORD_W-1:0] dout;
    sram_fifo_pkg::qmask_t  dout_valid;

    queue_pointers u_queue_pointers
    (
        .memclk          (memclk),
        .reset           (reset),
        .wr_valid        (wr_valid),
        .wr_queue        (wr_queue),
        .queue_id        (queue_id),
        .read_burst      (read_burst),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .rd_addr         (rd_addr),
        .mem_queue_empty (mem_queue_empty),
        .wr_full         (wr_full)
    );

    sram_model u_sram_model
    (
        .memclk  (memclk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (sram_addr),
        .rd_data (rd_data)
    );

    burst_reader u_burst_reader
    (
        .memclk       (memclk),
        .reset        (reset),
        .burst_inc    (burst_inc),
        .queue_id     (queue_id),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_en        (rd_en),
        .sram_addr    (sram_addr),
        .read_burst   (read_burst),
        .din_valid    (din_valid),
        .din          (din),
        .din_queue_id (din_queue_id)
    );

    drain_arbiter u_drain_arbiter
    (
        .memclk          (memclk),
        .reset           (reset),
        .full            (fifo_full),
        .mem_queue_empty (mem_queue_empty),
        .read_burst      (read_burst),
        .din_valid       (din_valid),
        .din             (din),
        .din_queue_id    (din_queue_id),
        .queue_id        (queue_id),
        .burst_inc       (burst_inc),
        .dout            (dout),
        .dout_valid      (dout_valid)
    );

    // One output FIFO per queue.
    for (genvar q = 0; q < `SF_NUM_QUEUES; q++)
    begin : g_out
        output_fifo u_output_fifo
        (
            .memclk  (memclk),
            .reset   (reset),
            .wr_en   (dout_valid[q]),
            .wr_data (dout[q*`SF_WORD_W +: `SF_WORD_W]),
            .rd_en   (out_rd_en[q]),
            .rd_data (out_data[q*`SF_WORD_W +: `SF_WORD_W]),
            .empty   (out_empty[q]),
            .full    (fifo_full[q])
        );
    end

endmodule

`default_nettype wire

/* hw/output_fifo.sv */
// Per-queue output FIFO
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_macros.svh"

module output_fifo
(
    input  wire logic                   memclk,
    input  wire logic                   reset,
    input  wire logic                   wr_en,
    input  sram_fifo_pkg::word_t        wr_data,
    input  wire logic                   rd_en,
    output sram_fifo_pkg::word_t        rd_data,
    output logic                        empty,
    output logic                        full
);

    localparam int DEPTH = `SF_OUT_DEPTH;
    localparam int CNT_W = `SF_OUT_ADDR_W + 1;

    sram_fifo_pkg::word_t       mem [DEPTH];
    logic [`SF_OUT_ADDR_W-1:0]  wr_ptr;
    logic [`SF_OUT_ADDR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       do_wr;
    logic                       do_rd;

    // Reads on empty are dropped.
    assign do_rd = rd_en && !empty;
    assign do_wr = wr_en && (count != CNT_W'(DEPTH));

    // First word fall-through.
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);

    // Under two bursts free, one may be in flight.
    assign full = (count > CNT_W'(DEPTH - 2*`SF_BURST_LEN));

    always_ff @(posedge memclk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // ***********************************************************************
    // Pointers and occupancy.
    // ***********************************************************************
    always_ff @(posedge memclk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/sram_model.sv */
// Synchronous SRAM model
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_macros.svh"

module sram_model
(
    input  wire logic                   memclk,
    input  wire logic                   wr_en,
    input  sram_fifo_pkg::addr_t        wr_addr,
    input  sram_fifo_pkg::word_t        wr_data,
    input  wire logic                   rd_en,
    input  sram_fifo_pkg::addr_t        rd_addr,
    output sram_fifo_pkg::word_t        rd_data
);

    localparam int WORDS = 1 << `SF_ADDR_W;

    // All four queue regions.
    sram_fifo_pkg::word_t mem [WORDS];

    // Write port.
    always_ff @(posedge memclk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle.
    always_ff @(posedge memclk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/burst_reader.sv */
// SRAM burst reader
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_macros.svh"

module burst_reader
(
    input  wire logic                   memclk,
    input  wire logic                   reset,
    input  sram_fifo_pkg::qmask_t       burst_inc,
    input  sram_fifo_pkg::qid_t         queue_id,
    input  sram_fifo_pkg::addr_t        rd_addr,
    input  sram_fifo_pkg::word_t        rd_data,
    output logic                        rd_en,
    output sram_fifo_pkg::addr_t        sram_addr,
    output logic                        read_burst,
    output logic                        din_valid,
    output sram_fifo_pkg::word_t        din,
    output sram_fifo_pkg::qid_t         din_queue_id
);

    sram_fifo_pkg::rd_state_e state;
    logic [`SF_BEAT_W-1:0]    beat;
    logic                     last_beat;

    // Queue sampled at start.
    sram_fifo_pkg::qid_t      cur_qid;

    // One address per cycle in RD_READ.
    assign rd_en      = (state == sram_fifo_pkg::RD_READ);
    assign last_beat  = &beat;
    assign read_burst = rd_en && last_beat;
    assign sram_addr  = rd_addr + sram_fifo_pkg::addr_t'(beat);

    // SRAM data is already one cycle late.
    assign din = rd_data;

    // ***********************************************************************
    // Burst FSM.
    // ***********************************************************************
    always_ff @(posedge memclk)
    begin
        if (reset)
        begin
            state     <= sram_fifo_pkg::RD_IDLE;
            beat      <= '0;
            din_valid <= 1'b0;
        end
        else
        begin
            // Strobe follows the address by the RAM latency.
            din_valid <= rd_en;
            case (state)
                sram_fifo_pkg::RD_IDLE:
                begin
                    beat <= '0;
                    if (|burst_inc)
                    begin
                        state <= sram_fifo_pkg::RD_READ;
                    end
                end
                sram_fifo_pkg::RD_READ:
                begin
                    beat <= beat + 1'b1;
                    if (last_beat)
                    begin
                        state <= sram_fifo_pkg::RD_DONE;
                    end
                end
                // Gap so the new empty level settles.
                default:
                begin
                    state <= sram_fifo_pkg::RD_IDLE;
                end
            endcase
        end
    end

    // Queue tag, delayed with the data.
    always_ff @(posedge memclk)
    begin
        if ((state == sram_fifo_pkg::RD_IDLE) && (|burst_inc))
        begin
            cur_qid <= queue_id;
        end
        din_queue_id <= cur_qid;
    end

endmodule

`default_nettype wire

/* hw/drain_arbiter.sv */
// Round-robin drain arbiter
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_macros.svh"

module drain_arbiter
(
    input  wire logic                               memclk,
    input  wire logic                               reset,
    input  sram_fifo_pkg::qmask_t                   full,
    input  sram_fifo_pkg::qmask_t                   mem_queue_empty,
    input  wire logic                               read_burst,
    input  wire logic                               din_valid,
    input  sram_fifo_pkg::word_t                    din,
    input  sram_fifo_pkg::qid_t                     din_queue_id,
    output sram_fifo_pkg::qid_t                     queue_id,
    output sram_fifo_pkg::qmask_t                   burst_inc,
    output logic [`SF_NUM_QUEUES*`SF_WORD_W-1:0]    dout,
    output sram_fifo_pkg::qmask_t                   dout_valid
);

    // Queue has a burst in SRAM and room at its output.
    sram_fifo_pkg::qmask_t ready;
    sram_fifo_pkg::qmask_t prev_ready;

    sram_fifo_pkg::qid_t   next_queue_id;
    sram_fifo_pkg::qid_t   cand;
    logic                  found;
    logic                  move;

    // Returned word, held one cycle.
    sram_fifo_pkg::word_t  prev_din;
    sram_fifo_pkg::qid_t   prev_din_queue_id;

    assign ready = ~mem_queue_empty & ~full;

    // ***********************************************************************
    // Next queue selection.
    // ***********************************************************************
    always_comb
    begin
        next_queue_id = queue_id;
        found         = 1'b0;
        cand          = queue_id;
        // Leave after a burst, or after two stalled cycles.
        // A burst still returning pins the queue.
        move = read_burst ||
               (!din_valid && !ready[queue_id] && !prev_ready[queue_id]);
        // Search starts just past the current queue.
        for (int i = 1; i < `SF_NUM_QUEUES; i++)
        begin
            cand = queue_id + sram_fifo_pkg::qid_t'(i);
            if (move && !found && ready[cand])
            begin
                next_queue_id = cand;
                found         = 1'b1;
            end
        end
    end

    // Start request for the reader.
    always_comb
    begin
        burst_inc           = '0;
        burst_inc[queue_id] = ready[queue_id];
    end

    always_ff @(posedge memclk)
    begin
        if (reset)
        begin
            queue_id   <= '0;
            prev_ready <= '0;
            dout_valid <= '0;
        end
        else
        begin
            queue_id   <= next_queue_id;
            prev_ready <= ready;
            // One-hot write strobe for the owning FIFO.
            if (din_valid)
            begin
                dout_valid <= sram_fifo_pkg::qmask_t'(1) << din_queue_id;
            end
            else
            begin
                dout_valid <= '0;
            end
        end
    end

    // ***********************************************************************
    // Steering of returned words.
    // ***********************************************************************
    always_ff @(posedge memclk)
    begin
        prev_din          <= din;
        prev_din_queue_id <= din_queue_id;
    end

    // Word lands in its own queue's slice.
    always_comb
    begin
        dout = '0;
        dout[prev_din_queue_id*`SF_WORD_W +: `SF_WORD_W] = prev_din;
    end

endmodule

`default_nettype wire

/* hw/queue_pointers.sv */
// Per-queue region pointers
`timescale 1ns/1ps
`default_nettype none

`include "sram_fifo_macros.svh"

module queue_pointers
(
    input  wire logic                   memclk,
    input  wire logic                   reset,
    input  wire logic                   wr_valid,
    input  sram_fifo_pkg::qid_t         wr_queue,
    input  sram_fifo_pkg::qid_t         queue_id,
    input  wire logic                   read_burst,
    output logic                        wr_en,
    output sram_fifo_pkg::addr_t        wr_addr,
    output sram_fifo_pkg::addr_t        rd_addr,
    output sram_fifo_pkg::qmask_t       mem_queue_empty,
    output sram_fifo_pkg::qmask_t       wr_full
);

    // Word index within a region, and burst index within a region.
    localparam int REG_W  = `SF_ADDR_W - `SF_QID_W;
    localparam int BIDX_W = REG_W - `SF_BEAT_W;
    localparam int CNT_W  = $clog2(`SF_REGION_BURSTS + 1);

    logic [REG_W-1:0]  wr_ptr [`SF_NUM_QUEUES];
    logic [BIDX_W-1:0] rd_ptr [`SF_NUM_QUEUES];
    logic [CNT_W-1:0]  bursts [`SF_NUM_QUEUES];

    // Per-queue commit and release strobes.
    sram_fifo_pkg::qmask_t commit;
    sram_fifo_pkg::qmask_t release_q;

    // Drop writes into a full region.
    assign wr_en   = wr_valid && !wr_full[wr_queue];
    assign wr_addr = {wr_queue, wr_ptr[wr_queue]};

    // Base of the oldest committed burst.
    assign rd_addr = {queue_id, rd_ptr[queue_id], {`SF_BEAT_W{1'b0}}};

    always_comb
    begin
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            mem_queue_empty[q] = (bursts[q] == '0);
            wr_full[q]         = (bursts[q] == CNT_W'(`SF_REGION_BURSTS));
            // Fourth word of a burst commits it.
            commit[q]    = wr_en && (wr_queue == q) && (&wr_ptr[q][`SF_BEAT_W-1:0]);
            release_q[q] = read_burst && (queue_id == q);
        end
    end

    // ***********************************************************************
    // Pointer and burst count update.
    // ***********************************************************************
    always_ff @(posedge memclk)
    begin
        if (reset)
        begin
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                bursts[q] <= '0;
            end
        end
        else
        begin
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                if (wr_en && (wr_queue == q))
                begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (release_q[q])
                begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                // Commit and release together leave the count alone.
                if (commit[q] && !release_q[q])
                begin
                    bursts[q] <= bursts[q] + 1'b1;
                end
                else if (!commit[q] && release_q[q])
                begin
                    bursts[q] <= bursts[q] - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sram_fifo_pkg.sv */
// SRAM packet buffer types
`default_nettype none

package sram_fifo_pkg;

    `include "sram_fifo_macros.svh"

    // One stored word, EOP in the top bit.
    typedef logic [`SF_WORD_W-1:0] word_t;

    // Queue index.
    typedef logic [`SF_QID_W-1:0] qid_t;

    // SRAM word address, queue in the top bits.
    typedef logic [`SF_ADDR_W-1:0] addr_t;

    // One bit per queue.
    typedef logic [`SF_NUM_QUEUES-1:0] qmask_t;

    // Burst reader states.
    typedef enum logic [1:0]
    {
        RD_IDLE,
        RD_READ,
        RD_DONE
    } rd_state_e;

endpackage

`default_nettype wire

/* hw/sram_fifo_macros.svh */
// SRAM packet buffer sizes
`ifndef SRAM_FIFO_MACROS_SVH
`define SRAM_FIFO_MACROS_SVH

// Queue count and queue index width.
`define SF_NUM_QUEUES    4
`define SF_QID_W         2

// Payload, plus one end-of-packet bit on top.
`define SF_DATA_W        32
`define SF_WORD_W        (`SF_DATA_W + 1)

// Burst geometry.
`define SF_BURST_LEN     4
`define SF_BEAT_W        2

// SRAM regions, 16 words per queue.
`define SF_REGION_BURSTS 4
`define SF_ADDR_W        6

// Output FIFO depth and pointer width.
`define SF_OUT_DEPTH     16
`define SF_OUT_ADDR_W    4

`endif
